// File: common/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Datapath widths
`define MIPS_DATA_W     32
`define MIPS_INSTR_W    32

// Register file geometry
`define MIPS_REG_CNT    32
`define MIPS_REG_AW     5

// Return address register for JAL
`define MIPS_LINK_REG   31

`endif

// File: common/mips_pkg.sv
package mips_pkg;

    // Primary opcodes, instruction bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,             // R type, operation selected by funct
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } opcode_e;

    // R type function codes that change the decode
    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001
    } funct_e;

    // Where a jump or branch takes its target from
    typedef enum logic [1:0] {
        ADDR_REG    = 2'b00,                // Target is the rs register
        ADDR_REGION = 2'b01,                // Upper PC bits joined to the 26-bit offset
        ADDR_PC_REL = 2'b10                 // pc+4 plus the scaled 16-bit offset
    } addr_type_e;

    // Memory access size, same coding as opcode bits 1:0
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b11
    } mem_size_e;

endpackage

// File: decode/branch_unit.sv
`timescale 1ns/100ps

`include "mips_cfg.svh"

module branch_unit (
    input  logic [`MIPS_DATA_W-1:0]  i_pc,
    input  logic                     i_pc_modify,
    input  logic                     i_link_ret,
    input  mips_pkg::addr_type_e     i_addr_type,
    input  logic                     i_equal,
    input  logic [15:0]              i_imm,
    input  logic [25:0]              i_addr_offset,
    input  logic [`MIPS_DATA_W-1:0]  i_rs_data,
    input  logic [`MIPS_DATA_W-1:0]  i_rt_data,

    output logic                     o_taken,
    output logic [`MIPS_DATA_W-1:0]  o_target,
    output logic [`MIPS_DATA_W-1:0]  o_link_value
);

    logic [`MIPS_DATA_W-1:0] pc_plus4;
    logic [`MIPS_DATA_W-1:0] br_offset;
    logic                    operands_eq;

    assign pc_plus4    = i_pc + `MIPS_DATA_W'(4);
    assign br_offset   = {{(`MIPS_DATA_W-18){i_imm[15]}}, i_imm, 2'b00};  // Sign extend, x4
    assign operands_eq = (i_rs_data == i_rt_data);

    always_comb begin
        o_taken  = 1'b0;
        o_target = '0;
        if (i_pc_modify) begin
            case (i_addr_type)
                mips_pkg::ADDR_REG: begin
                    o_taken  = 1'b1;
                    o_target = i_rs_data;
                end
                mips_pkg::ADDR_REGION: begin
                    o_taken  = 1'b1;
                    o_target = {pc_plus4[`MIPS_DATA_W-1:28], i_addr_offset, 2'b00};
                end
                mips_pkg::ADDR_PC_REL: begin
                    o_taken  = i_equal ? operands_eq : !operands_eq;  // BEQ or BNE
                    o_target = pc_plus4 + br_offset;
                end
                default: begin
                    o_taken  = 1'b0;
                end
            endcase
        end
    end

    // Return address skips the delay slot
    assign o_link_value = i_link_ret ? (i_pc + `MIPS_DATA_W'(8)) : '0;

    a_taken_needs_modify: assert final (!o_taken || i_pc_modify)
        else $error("branch_unit: taken without a jump or branch");

endmodule

// File: decode/instr_decoder.sv
`timescale 1ns/100ps

`include "mips_cfg.svh"

module instr_decoder (
    input  logic [`MIPS_INSTR_W-1:0]  i_instr,

    output mips_pkg::opcode_e         o_opcode,
    output logic [5:0]                o_funct,       // R type funct or low opcode bits
    output logic [`MIPS_REG_AW-1:0]   o_rs,
    output logic [`MIPS_REG_AW-1:0]   o_rt,
    output logic [`MIPS_REG_AW-1:0]   o_rd,
    output logic [4:0]                o_sa,
    output logic [15:0]               o_imm,
    output logic [25:0]               o_addr_offset, // Jump region offset

    output logic                      o_pc_modify,   // Jump or branch
    output logic                      o_link_ret,    // Saves a return address
    output mips_pkg::addr_type_e      o_addr_type,
    output logic                      o_equal,       // Branch on equal operands
    output logic                      o_is_imm,
    output logic                      o_mem_op,
    output logic                      o_mem_store,   // Store when set, load otherwise
    output mips_pkg::mem_size_e       o_mem_size,
    output logic                      o_mem_unsign,
    output logic [`MIPS_REG_AW-1:0]   o_wb_reg,      // Destination, zero when none
    output logic                      o_illegal
);

    assign o_opcode = mips_pkg::opcode_e'(i_instr[31:26]);

    always_comb begin
        o_funct       = '0;
        o_rs          = '0;
        o_rt          = '0;
        o_rd          = '0;
        o_sa          = '0;
        o_imm         = '0;
        o_addr_offset = '0;
        o_pc_modify   = 1'b0;
        o_link_ret    = 1'b0;
        o_addr_type   = mips_pkg::ADDR_REG;
        o_equal       = 1'b0;
        o_is_imm      = 1'b0;
        o_mem_op      = 1'b0;
        o_mem_store   = 1'b0;
        o_mem_size    = mips_pkg::SIZE_BYTE;
        o_mem_unsign  = 1'b0;
        o_wb_reg      = '0;
        o_illegal     = 1'b0;

        case (o_opcode)
            mips_pkg::OP_SPECIAL: begin
                o_rs = i_instr[25:21];
                case (mips_pkg::funct_e'(i_instr[5:0]))
                    mips_pkg::FN_JR: begin
                        o_pc_modify = 1'b1;              // Target from rs, no link
                    end
                    mips_pkg::FN_JALR: begin
                        o_rd        = i_instr[15:11];
                        o_pc_modify = 1'b1;
                        o_link_ret  = 1'b1;
                        o_wb_reg    = i_instr[15:11];    // Return address into rd
                    end
                    default: begin
                        o_funct  = i_instr[5:0];
                        o_rt     = i_instr[20:16];
                        o_rd     = i_instr[15:11];
                        o_sa     = i_instr[10:6];
                        o_wb_reg = i_instr[15:11];
                    end
                endcase
            end
            mips_pkg::OP_J,
            mips_pkg::OP_JAL: begin
                o_addr_offset = i_instr[25:0];
                o_pc_modify   = 1'b1;
                o_addr_type   = mips_pkg::ADDR_REGION;
                if (o_opcode == mips_pkg::OP_JAL) begin
                    o_link_ret = 1'b1;
                    o_wb_reg   = `MIPS_REG_AW'(`MIPS_LINK_REG);
                end
            end
            mips_pkg::OP_BEQ,
            mips_pkg::OP_BNE: begin
                o_rs        = i_instr[25:21];
                o_rt        = i_instr[20:16];
                o_imm       = i_instr[15:0];             // Word offset from pc+4
                o_pc_modify = 1'b1;
                o_addr_type = mips_pkg::ADDR_PC_REL;
                o_equal     = (o_opcode == mips_pkg::OP_BEQ);
                o_is_imm    = 1'b1;
            end
            mips_pkg::OP_ADDI, mips_pkg::OP_ADDIU,
            mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
            mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
                o_funct  = {3'b000, i_instr[28:26]};     // ALU op from opcode
                o_rs     = i_instr[25:21];
                o_rt     = i_instr[20:16];
                o_imm    = i_instr[15:0];
                o_is_imm = 1'b1;
                o_wb_reg = i_instr[20:16];
            end
            mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW,
            mips_pkg::OP_LBU, mips_pkg::OP_LHU: begin
                o_funct      = {3'b000, i_instr[28:26]};
                o_rs         = i_instr[25:21];           // Base address
                o_rt         = i_instr[20:16];
                o_imm        = i_instr[15:0];
                o_is_imm     = 1'b1;
                o_mem_op     = 1'b1;
                o_mem_size   = mips_pkg::mem_size_e'(i_instr[27:26]);
                o_mem_unsign = i_instr[28];
                o_wb_reg     = i_instr[20:16];
            end
            mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW: begin
                o_funct     = {3'b000, i_instr[28:26]};
                o_rs        = i_instr[25:21];
                o_rt        = i_instr[20:16];            // Store data
                o_imm       = i_instr[15:0];
                o_is_imm    = 1'b1;
                o_mem_op    = 1'b1;
                o_mem_store = 1'b1;
                o_mem_size  = mips_pkg::mem_size_e'(i_instr[27:26]);
            end
            default: begin
                o_illegal = 1'b1;                        // Unknown opcode, no side effects
            end
        endcase
    end

    // A memory access never redirects the PC
    a_mem_not_jump: assert final (o_illegal || !(o_mem_op && o_pc_modify))
        else $error("instr_decoder: memory op and PC modify both set");

endmodule

// File: decode/reg_file.sv
`timescale 1ns/100ps

`include "mips_cfg.svh"

module reg_file (
    input  logic                     i_clk,
    input  logic                     i_rst_n,

    input  logic [`MIPS_REG_AW-1:0]  i_rs_addr,
    input  logic [`MIPS_REG_AW-1:0]  i_rt_addr,
    output logic [`MIPS_DATA_W-1:0]  o_rs_data,
    output logic [`MIPS_DATA_W-1:0]  o_rt_data,

    input  logic                     i_wr_en,
    input  logic [`MIPS_REG_AW-1:0]  i_wr_addr,
    input  logic [`MIPS_DATA_W-1:0]  i_wr_data
);

    // Register 0 has no storage
    logic [`MIPS_DATA_W-1:0] regs [1:`MIPS_REG_CNT-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < `MIPS_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;            // Writes to register 0 dropped
        end
    end

    // Reads see the value before this cycle's write
    assign o_rs_data = (i_rs_addr == '0) ? '0 : regs[i_rs_addr];
    assign o_rt_data = (i_rt_addr == '0) ? '0 : regs[i_rt_addr];

    // Register 0 stays zero even right after a write to it
    property p_zero_reg;
        @(posedge i_clk) disable iff (!i_rst_n)
            ((i_rs_addr == '0) |-> (o_rs_data == '0)) and
            ((i_rt_addr == '0) |-> (o_rt_data == '0));
    endproperty

    a_zero_reg: assert property (p_zero_reg)
        else $error("reg_file: register 0 read nonzero");

endmodule

// File: design/decode_stage.sv
`timescale 1ns/100ps

`include "mips_cfg.svh"

module decode_stage (
    input  logic                     i_clk,
    input  logic                     i_rst_n,

    input  logic                     i_valid,        // One pulse per instruction
    input  logic                     i_stall,        // Hold the ID/EX register
    input  logic [`MIPS_INSTR_W-1:0] i_instr,
    input  logic [`MIPS_DATA_W-1:0]  i_pc,

    input  logic                     i_wb_en,
    input  logic [`MIPS_REG_AW-1:0]  i_wb_addr,
    input  logic [`MIPS_DATA_W-1:0]  i_wb_data,

    output logic                     o_valid,
    output logic [5:0]               o_funct,
    output logic [`MIPS_DATA_W-1:0]  o_rs_data,
    output logic [`MIPS_DATA_W-1:0]  o_rt_data,
    output logic [`MIPS_REG_AW-1:0]  o_rd,
    output logic [4:0]               o_sa,
    output logic [15:0]              o_imm,
    output logic                     o_is_imm,
    output logic                     o_mem_op,
    output logic                     o_mem_store,
    output mips_pkg::mem_size_e      o_mem_size,
    output logic                     o_mem_unsign,
    output logic [`MIPS_REG_AW-1:0]  o_wb_reg,
    output logic                     o_branch_taken,
    output logic [`MIPS_DATA_W-1:0]  o_branch_target,
    output logic [`MIPS_DATA_W-1:0]  o_link_value,
    output logic                     o_illegal
);

    logic [5:0]              dec_funct;
    logic [`MIPS_REG_AW-1:0] dec_rs;
    logic [`MIPS_REG_AW-1:0] dec_rt;
    logic [`MIPS_REG_AW-1:0] dec_rd;
    logic [4:0]              dec_sa;
    logic [15:0]             dec_imm;
    logic [25:0]             dec_addr_offset;
    logic                    dec_pc_modify;
    logic                    dec_link_ret;
    mips_pkg::addr_type_e    dec_addr_type;
    logic                    dec_equal;
    logic                    dec_is_imm;
    logic                    dec_mem_op;
    logic                    dec_mem_store;
    mips_pkg::mem_size_e     dec_mem_size;
    logic                    dec_mem_unsign;
    logic [`MIPS_REG_AW-1:0] dec_wb_reg;
    logic                    dec_illegal;
    logic [`MIPS_DATA_W-1:0] rs_data;
    logic [`MIPS_DATA_W-1:0] rt_data;
    logic                    br_taken;
    logic [`MIPS_DATA_W-1:0] br_target;
    logic [`MIPS_DATA_W-1:0] link_value;
    logic                    capture;

    instr_decoder instr_decoder_i (
        .i_instr       (i_instr),
        .o_opcode      (),
        .o_funct       (dec_funct),
        .o_rs          (dec_rs),
        .o_rt          (dec_rt),
        .o_rd          (dec_rd),
        .o_sa          (dec_sa),
        .o_imm         (dec_imm),
        .o_addr_offset (dec_addr_offset),
        .o_pc_modify   (dec_pc_modify),
        .o_link_ret    (dec_link_ret),
        .o_addr_type   (dec_addr_type),
        .o_equal       (dec_equal),
        .o_is_imm      (dec_is_imm),
        .o_mem_op      (dec_mem_op),
        .o_mem_store   (dec_mem_store),
        .o_mem_size    (dec_mem_size),
        .o_mem_unsign  (dec_mem_unsign),
        .o_wb_reg      (dec_wb_reg),
        .o_illegal     (dec_illegal)
    );

    reg_file reg_file_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_rs_addr (dec_rs),
        .i_rt_addr (dec_rt),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_wr_en   (i_wb_en),
        .i_wr_addr (i_wb_addr),
        .i_wr_data (i_wb_data)
    );

    branch_unit branch_unit_i (
        .i_pc          (i_pc),
        .i_pc_modify   (dec_pc_modify),
        .i_link_ret    (dec_link_ret),
        .i_addr_type   (dec_addr_type),
        .i_equal       (dec_equal),
        .i_imm         (dec_imm),
        .i_addr_offset (dec_addr_offset),
        .i_rs_data     (rs_data),
        .i_rt_data     (rt_data),
        .o_taken       (br_taken),
        .o_target      (br_target),
        .o_link_value  (link_value)
    );

    assign capture = i_valid && !i_stall;               // Valid during stall is dropped

    // ID/EX register
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid         <= 1'b0;
            o_funct         <= '0;
            o_rs_data       <= '0;
            o_rt_data       <= '0;
            o_rd            <= '0;
            o_sa            <= '0;
            o_imm           <= '0;
            o_is_imm        <= 1'b0;
            o_mem_op        <= 1'b0;
            o_mem_store     <= 1'b0;
            o_mem_size      <= mips_pkg::SIZE_BYTE;
            o_mem_unsign    <= 1'b0;
            o_wb_reg        <= '0;
            o_branch_taken  <= 1'b0;
            o_branch_target <= '0;
            o_link_value    <= '0;
            o_illegal       <= 1'b0;
        end else if (capture) begin
            o_valid         <= 1'b1;
            o_funct         <= dec_funct;
            o_rs_data       <= rs_data;
            o_rt_data       <= rt_data;
            o_rd            <= dec_rd;
            o_sa            <= dec_sa;
            o_imm           <= dec_imm;
            o_is_imm        <= dec_is_imm;
            o_mem_op        <= dec_mem_op;
            o_mem_store     <= dec_mem_store;
            o_mem_size      <= dec_mem_size;
            o_mem_unsign    <= dec_mem_unsign;
            o_wb_reg        <= dec_wb_reg;
            o_branch_taken  <= br_taken;
            o_branch_target <= br_target;
            o_link_value    <= link_value;
            o_illegal       <= dec_illegal;
        end else if (!i_stall) begin
            o_valid         <= 1'b0;                    // Payload kept while valid drops
        end
    end

    a_valid_known: assert property (@(posedge i_clk) disable iff (!i_rst_n) !$isunknown(o_valid))
        else $error("decode_stage: o_valid unknown");

endmodule

// File: tb.f
+incdir+common
common/mips_pkg.sv
decode/instr_decoder.sv
decode/reg_file.sv
decode/branch_unit.sv
design/decode_stage.sv
verif/decode_stage_tb.sv

// File: verif/decode_stage_tb.sv
`timescale 1ns/100ps

`include "mips_cfg.svh"

module decode_stage_tb;

    typedef struct packed {
        logic [5:0]  funct;
        logic [31:0] rs_data;
        logic [31:0] rt_data;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        logic        is_imm;
        logic        mem_op;
        logic        mem_store;
        logic [1:0]  mem_size;
        logic        mem_unsign;
        logic [4:0]  wb_reg;
        logic        taken;
        logic [31:0] target;
        logic [31:0] link;
        logic        illegal;
    } expect_t;

    logic        i_clk, i_rst_n, i_valid, i_stall, i_wb_en;
    logic [31:0] i_instr, i_pc, i_wb_data;
    logic [4:0]  i_wb_addr;
    logic        o_valid, o_is_imm, o_mem_op, o_mem_store, o_mem_unsign;
    logic        o_branch_taken, o_illegal;
    logic [5:0]  o_funct;
    logic [31:0] o_rs_data, o_rt_data, o_branch_target, o_link_value;
    logic [4:0]  o_rd, o_sa, o_wb_reg;
    logic [15:0] o_imm;
    mips_pkg::mem_size_e o_mem_size;

    integer      seed = 20558;
    logic [31:0] shadow [0:31];                      // Mirrors every write-back issued
    expect_t     exp_q [$];
    string       name_q [$];
    int          sent_cnt = 0;
    int          valid_cnt = 0;
    int          test_cnt = 0;
    int          err_cnt = 0;
    logic        timed_out = 1'b0;

    decode_stage dut_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_valid         (i_valid),
        .i_stall         (i_stall),
        .i_instr         (i_instr),
        .i_pc            (i_pc),
        .i_wb_en         (i_wb_en),
        .i_wb_addr       (i_wb_addr),
        .i_wb_data       (i_wb_data),
        .o_valid         (o_valid),
        .o_funct         (o_funct),
        .o_rs_data       (o_rs_data),
        .o_rt_data       (o_rt_data),
        .o_rd            (o_rd),
        .o_sa            (o_sa),
        .o_imm           (o_imm),
        .o_is_imm        (o_is_imm),
        .o_mem_op        (o_mem_op),
        .o_mem_store     (o_mem_store),
        .o_mem_size      (o_mem_size),
        .o_mem_unsign    (o_mem_unsign),
        .o_wb_reg        (o_wb_reg),
        .o_branch_taken  (o_branch_taken),
        .o_branch_target (o_branch_target),
        .o_link_value    (o_link_value),
        .o_illegal       (o_illegal)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Expected ID/EX contents for one instruction
    function automatic expect_t decode_ref(input logic [31:0] instr, input logic [31:0] pc,
                                           input logic [31:0] regs [0:31]);
        expect_t     e;
        logic [5:0]  op;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] pc4;
        e      = '0;
        op     = instr[31:26];
        rs_val = (instr[25:21] == 5'd0) ? 32'd0 : regs[instr[25:21]];  // Register 0 reads zero
        rt_val = (instr[20:16] == 5'd0) ? 32'd0 : regs[instr[20:16]];
        pc4    = pc + 32'd4;
        if (op == mips_pkg::OP_SPECIAL) begin
            e.rs_data = rs_val;
            if (instr[5:0] == mips_pkg::FN_JR || instr[5:0] == mips_pkg::FN_JALR) begin
                e.taken  = 1'b1;
                e.target = rs_val;
                if (instr[5:0] == mips_pkg::FN_JALR) begin
                    e.rd     = instr[15:11];
                    e.wb_reg = instr[15:11];
                    e.link   = pc + 32'd8;
                end
            end else begin
                e.funct   = instr[5:0];
                e.rt_data = rt_val;
                e.rd      = instr[15:11];
                e.sa      = instr[10:6];
                e.wb_reg  = instr[15:11];
            end
        end else if (op == mips_pkg::OP_J || op == mips_pkg::OP_JAL) begin
            e.taken  = 1'b1;
            e.target = {pc4[31:28], instr[25:0], 2'b00};
            if (op == mips_pkg::OP_JAL) begin
                e.wb_reg = 5'(`MIPS_LINK_REG);
                e.link   = pc + 32'd8;
            end
        end else if (op == mips_pkg::OP_BEQ || op == mips_pkg::OP_BNE) begin
            e.rs_data = rs_val;
            e.rt_data = rt_val;
            e.imm     = instr[15:0];
            e.is_imm  = 1'b1;
            e.taken   = (op == mips_pkg::OP_BEQ) == (rs_val == rt_val);
            e.target  = pc4 + {{14{instr[15]}}, instr[15:0], 2'b00};
        end else if (op[5:3] == 3'b001 || op == mips_pkg::OP_LB || op == mips_pkg::OP_LH ||
                     op == mips_pkg::OP_LW || op == mips_pkg::OP_LBU || op == mips_pkg::OP_LHU ||
                     op == mips_pkg::OP_SB || op == mips_pkg::OP_SH || op == mips_pkg::OP_SW) begin
            e.funct   = {3'b000, op[2:0]};
            e.rs_data = rs_val;
            e.rt_data = rt_val;
            e.imm     = instr[15:0];
            e.is_imm  = 1'b1;
            e.mem_op  = op[5];
            e.wb_reg  = (op[5:3] == 3'b101) ? 5'd0 : instr[20:16];  // Stores write nothing
            if (op[5]) begin
                e.mem_store  = op[3];
                e.mem_size   = op[1:0];
                e.mem_unsign = op[2] && !op[3];
            end
        end else begin
            e.illegal = 1'b1;
        end
        return e;
    endfunction

    function automatic logic [31:0] random_pc();
        logic [31:0] r;
        r = $random(seed);
        return {r[31:2], 2'b00};
    endfunction

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] exp_v, input logic [31:0] act_v);
        $display("error %s %s: expected %h actual %h", name, field, exp_v, act_v);
        err_cnt++;
    endtask

    task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
        shadow[addr] = data;
        i_wb_en      = 1'b1;
        i_wb_addr    = addr;
        i_wb_data    = data;
        @(negedge i_clk);
        i_wb_en = 1'b0;
    endtask

    task automatic send_instr(input string name, input logic [31:0] instr,
                              input logic [31:0] pc);
        exp_q.push_back(decode_ref(instr, pc, shadow));
        name_q.push_back(name);
        sent_cnt++;
        i_instr = instr;
        i_pc    = pc;
        i_valid = 1'b1;
        @(negedge i_clk);
        i_valid = 1'b0;
    endtask

    // Compare process checks each new o_valid
    initial begin : compare_proc
        expect_t e;
        string   name;
        logic    edge_stalled;
        int      idle;
        int      errs_before;
        idle = 0;
        while (!timed_out) begin
            @(posedge i_clk);
            edge_stalled = i_stall;                  // Held valid under stall is not new
            @(negedge i_clk);
            if (o_valid === 1'b1 && !edge_stalled) begin
                valid_cnt++;
                idle = 0;
                if (exp_q.size() == 0) begin
                    $display("o_valid appeared with no instruction outstanding");
                    err_cnt++;
                end else begin
                    e           = exp_q.pop_front();
                    name        = name_q.pop_front();
                    errs_before = err_cnt;
                    if (o_funct !== e.funct) report_mismatch(name, "funct", e.funct, o_funct);
                    if (o_rs_data !== e.rs_data)
                        report_mismatch(name, "rs_data", e.rs_data, o_rs_data);
                    if (o_rt_data !== e.rt_data)
                        report_mismatch(name, "rt_data", e.rt_data, o_rt_data);
                    if (o_rd !== e.rd) report_mismatch(name, "rd", e.rd, o_rd);
                    if (o_sa !== e.sa) report_mismatch(name, "sa", e.sa, o_sa);
                    if (o_imm !== e.imm) report_mismatch(name, "imm", e.imm, o_imm);
                    if (o_is_imm !== e.is_imm)
                        report_mismatch(name, "is_imm", e.is_imm, o_is_imm);
                    if (o_mem_op !== e.mem_op) report_mismatch(name, "mem_op", e.mem_op, o_mem_op);
                    if (o_mem_store !== e.mem_store)
                        report_mismatch(name, "mem_store", e.mem_store, o_mem_store);
                    if (o_mem_size !== e.mem_size)
                        report_mismatch(name, "mem_size", e.mem_size, o_mem_size);
                    if (o_mem_unsign !== e.mem_unsign)
                        report_mismatch(name, "mem_unsign", e.mem_unsign, o_mem_unsign);
                    if (o_wb_reg !== e.wb_reg)
                        report_mismatch(name, "wb_reg", e.wb_reg, o_wb_reg);
                    if (o_branch_taken !== e.taken)
                        report_mismatch(name, "taken", e.taken, o_branch_taken);
                    if (o_branch_target !== e.target)
                        report_mismatch(name, "target", e.target, o_branch_target);
                    if (o_link_value !== e.link)
                        report_mismatch(name, "link", e.link, o_link_value);
                    if (o_illegal !== e.illegal)
                        report_mismatch(name, "illegal", e.illegal, o_illegal);
                    test_cnt++;
                    $display("test %s done, %0d mismatches", name, err_cnt - errs_before);
                end
            end else if (exp_q.size() != 0) begin
                idle++;
                if (idle > 10) begin
                    $display("Timeout: no o_valid for test %s", name_q[0]);
                    timed_out = 1'b1;
                end
            end else begin
                idle = 0;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [5:0]  op;
        logic [47:0] mem_ops;
        logic [31:0] held_instr;
        logic [31:0] held_pc;
        expect_t     held;
        int          errs_before;
        int          guard;
        i_rst_n   = 1'b0;
        i_valid   = 1'b0;
        i_stall   = 1'b0;
        i_instr   = '0;
        i_pc      = '0;
        i_wb_en   = 1'b0;
        i_wb_addr = '0;
        i_wb_data = '0;
        mem_ops   = {mips_pkg::OP_LB, mips_pkg::OP_LH, mips_pkg::OP_LW, mips_pkg::OP_LBU,
                     mips_pkg::OP_LHU, mips_pkg::OP_SB, mips_pkg::OP_SH, mips_pkg::OP_SW};
        repeat (4) @(negedge i_clk);
        i_rst_n = 1'b1;

        errs_before = err_cnt;
        if (o_valid !== 1'b0) report_mismatch("reset", "o_valid", 0, o_valid);
        if (o_branch_taken !== 1'b0) report_mismatch("reset", "taken", 0, o_branch_taken);
        if (o_illegal !== 1'b0) report_mismatch("reset", "illegal", 0, o_illegal);
        test_cnt++;
        $display("test reset done, %0d mismatches", err_cnt - errs_before);

        for (int a = 0; a < 32; a++) begin
            r = $random(seed);
            write_reg(a[4:0], r);                    // Includes a write to register 0
        end
        r = $random(seed);
        send_instr("r_type", {6'h00, 5'd3, 5'd7, 5'd12, r[10:6], 6'h20}, random_pc());
        send_instr("r_type_zero", {6'h00, 5'd0, 5'd0, 5'd4, r[15:11], 6'h25}, random_pc());

        for (int k = 0; k < 16; k++) begin
            op = (k < 8) ? (6'h08 + k[5:0]) : mem_ops[(15 - k) * 6 +: 6];
            r  = $random(seed);
            send_instr($sformatf("imm_op_%02h", op), {op, r[25:0]}, random_pc());
        end

        write_reg(5'd6, shadow[5] ^ 32'h1);          // Operands that differ
        for (int b = 0; b < 4; b++) begin
            op = b[0] ? mips_pkg::OP_BNE : mips_pkg::OP_BEQ;
            r  = $random(seed);
            send_instr($sformatf("%s_%s", b[0] ? "bne" : "beq", b[1] ? "diff" : "same"),
                       {op, 5'd5, b[1] ? 5'd6 : 5'd5, r[15:0]}, random_pc());
        end

        r = $random(seed);
        send_instr("j", {mips_pkg::OP_J, r[25:0]}, random_pc());
        r = $random(seed);
        send_instr("jal", {mips_pkg::OP_JAL, r[25:0]}, random_pc());
        send_instr("jr", {6'h00, 5'd9, 15'd0, mips_pkg::FN_JR}, random_pc());
        r = $random(seed);
        send_instr("jalr", {6'h00, 5'd10, 5'd0, r[15:11], 5'd0, mips_pkg::FN_JALR}, random_pc());

        r          = $random(seed);
        held_instr = {mips_pkg::OP_JAL, r[25:0]};
        held_pc    = random_pc();
        held       = decode_ref(held_instr, held_pc, shadow);
        send_instr("stall_capture", held_instr, held_pc);
        i_stall     = 1'b1;
        i_instr     = {mips_pkg::OP_J, ~r[25:0]};    // New decode must not leak through
        i_pc        = random_pc();
        errs_before = err_cnt;
        for (int c = 0; c < 4; c++) begin
            @(negedge i_clk);
            if (o_valid !== 1'b1) report_mismatch("stall", "o_valid", 1, o_valid);
            if (o_branch_taken !== held.taken)
                report_mismatch("stall", "taken", held.taken, o_branch_taken);
            if (o_branch_target !== held.target)
                report_mismatch("stall", "target", held.target, o_branch_target);
            if (o_link_value !== held.link)
                report_mismatch("stall", "link", held.link, o_link_value);
            if (o_wb_reg !== held.wb_reg)
                report_mismatch("stall", "wb_reg", held.wb_reg, o_wb_reg);
        end
        i_stall = 1'b0;
        @(negedge i_clk);
        if (o_valid !== 1'b0) report_mismatch("stall_release", "o_valid", 0, o_valid);
        test_cnt++;
        $display("test stall done, %0d mismatches", err_cnt - errs_before);

        r = $random(seed);
        send_instr("illegal_3f", {6'h3f, r[25:0]}, random_pc());
        send_instr("illegal_01", {6'h01, r[25:0]}, random_pc());

        guard = 0;
        while (exp_q.size() != 0 && !timed_out && guard < 50) begin
            @(negedge i_clk);
            guard++;
        end
        if (timed_out || exp_q.size() != 0) begin
            $display("Timeout: DUT stopped producing o_valid, %0d results missing",
                     exp_q.size());
            err_cnt++;
        end else if (valid_cnt != sent_cnt) begin
            $display("Saw %0d o_valid pulses for %0d accepted instructions",
                     valid_cnt, sent_cnt);
            err_cnt++;
        end
        $display("%0d tests run, %0d errors", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
